/* rtl/ip_frag_pkg.sv */
`default_nettype none

package ip_frag_pkg;

localparam int RECEIVE_QUEUE_SLOTS = 2;
localparam int FRAGMENT_SLOTS      = 2;
localparam int QUEUE_DEPTH         = 16;
localparam int SLOT_DEPTH          = 64;

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

typedef logic [7:0]  byte_t;
typedef logic [15:0] packet_id_t;
// Offset in units of 8 bytes
typedef logic [12:0] frag_offset_t;
typedef logic [15:0] timer_count_t;

typedef logic [$clog2(RECEIVE_QUEUE_SLOTS)-1:0] port_index_t;
typedef logic [$clog2(FRAGMENT_SLOTS)-1:0]      slot_index_t;

// Idle cycles after the last byte before a push is closed
localparam timer_count_t TIMEOUT_LIMIT = 16'd4;

//////////////////////////////////////////////////
// Bundles
//////////////////////////////////////////////////

typedef struct packed {
    packet_id_t   packet_id;
    logic         more_fragments;
    frag_offset_t offset;
} frag_header_t;

typedef struct packed {
    byte_t data;
    logic  last;
} byte_beat_t;

typedef struct packed {
    byte_t data;
    logic  last;
} push_beat_t;

typedef struct packed {
    logic         valid;
    frag_header_t header;
} frag_request_t;

endpackage

`default_nettype wire

/* rtl/cycle_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_timer (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire                        enable,
    input  wire                        load_count,
    input  wire ip_frag_pkg::timer_count_t count,
    output logic                       expired
);

import ip_frag_pkg::*;

timer_count_t remaining;

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        remaining <= '0;
    end
    else if (load_count) begin
        remaining <= count;
    end
    else if (enable && (remaining != '0)) begin
        remaining <= remaining - timer_count_t'(1);
    end
end

// Stays set at zero until the next load
assign expired = (remaining == '0);

endmodule

`default_nettype wire

/* rtl/receive_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module receive_queue (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire ip_frag_pkg::frag_header_t in_header,
    input  wire ip_frag_pkg::byte_beat_t   in_beat,
    input  wire                          in_valid,
    output logic                         in_ready,
    output ip_frag_pkg::frag_request_t   request,
    output ip_frag_pkg::byte_t           data,
    output logic                         data_valid,
    input  wire                          data_ready
);

import ip_frag_pkg::*;

typedef logic [$clog2(QUEUE_DEPTH)-1:0]   queue_addr_t;
typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count_t;

byte_t        mem [QUEUE_DEPTH];
queue_addr_t  write_ptr;
queue_addr_t  read_ptr;
queue_count_t fill_count;
frag_header_t header;
logic         complete;
logic         running;
logic         push;

assign push = in_valid && in_ready;

// Input closes once a whole fragment sits in the buffer
assign in_ready   = running && !complete && (fill_count != queue_count_t'(QUEUE_DEPTH));
assign data       = mem[read_ptr];
assign data_valid = complete;
assign request    = '{valid: complete, header: header};

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        running    <= 1'b0;
        write_ptr  <= '0;
        read_ptr   <= '0;
        fill_count <= '0;
        complete   <= 1'b0;
    end
    else begin
        running <= 1'b1;
        if (push) begin
            write_ptr  <= write_ptr + queue_addr_t'(1);
            fill_count <= fill_count + queue_count_t'(1);
            if (in_beat.last) begin
                complete <= 1'b1;
            end
        end
        else if (data_ready) begin
            read_ptr   <= read_ptr + queue_addr_t'(1);
            fill_count <= fill_count - queue_count_t'(1);
            // Final byte leaves
            if (fill_count == queue_count_t'(1)) begin
                complete <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clock) begin
    if (push) begin
        mem[write_ptr] <= in_beat.data;
    end
    if (push && (fill_count == '0)) begin
        header <= in_header;
    end
end

// Handler pops only a fully stored fragment
a_pop_needs_data: assert property (@(posedge clock) disable iff (!reset_n)
    data_ready |-> data_valid)
    else $error("receive_queue: pop without valid data");

endmodule

`default_nettype wire

/* rtl/fragment_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module fragment_slot (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire ip_frag_pkg::push_beat_t  push_beat,
    input  wire                         push_valid,
    input  wire ip_frag_pkg::packet_id_t  push_packet_id,
    output logic                        slot_empty,
    output ip_frag_pkg::packet_id_t     slot_packet_id,
    output ip_frag_pkg::byte_beat_t     out_beat,
    output logic                        out_valid,
    input  wire                         out_ready,
    output ip_frag_pkg::packet_id_t     out_packet_id
);

import ip_frag_pkg::*;

typedef logic [$clog2(SLOT_DEPTH)-1:0]   slot_addr_t;
typedef logic [$clog2(SLOT_DEPTH+1)-1:0] slot_count_t;

typedef enum logic [1:0] {
    vacant,
    filling,
    streaming
} slot_state_t;

slot_state_t state;
byte_t       mem [SLOT_DEPTH];
slot_count_t fill_count;
slot_addr_t  read_ptr;
packet_id_t  packet_id;
logic        final_beat;

assign final_beat     = (slot_count_t'(read_ptr) == (fill_count - slot_count_t'(1)));
assign slot_empty     = (state == vacant);
assign slot_packet_id = packet_id;
assign out_packet_id  = packet_id;
assign out_valid      = (state == streaming);
assign out_beat       = '{data: mem[read_ptr], last: out_valid && final_beat};

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        state      <= vacant;
        fill_count <= '0;
        read_ptr   <= '0;
    end
    else begin
        case (state)
            vacant, filling: begin
                if (push_valid) begin
                    fill_count <= fill_count + slot_count_t'(1);
                    state      <= push_beat.last ? streaming : filling;
                end
            end
            streaming: begin
                if (out_ready && final_beat) begin
                    state      <= vacant;
                    fill_count <= '0;
                    read_ptr   <= '0;
                end
                else if (out_ready) begin
                    read_ptr <= read_ptr + slot_addr_t'(1);
                end
            end
            default: begin
                state <= vacant;
            end
        endcase
    end
end

always_ff @(posedge clock) begin
    if (push_valid) begin
        mem[slot_addr_t'(fill_count)] <= push_beat.data;
    end
    // Identification taken from the first byte of a datagram
    if (push_valid && (state == vacant)) begin
        packet_id <= push_packet_id;
    end
end

a_no_push_when_busy: assert property (@(posedge clock) disable iff (!reset_n)
    push_valid |-> (state != streaming) && (fill_count != slot_count_t'(SLOT_DEPTH)))
    else $error("fragment_slot: push while streaming or full");

endmodule

`default_nettype wire

/* rtl/udp_receive_handler.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_receive_handler (
    input  wire                                      clock,
    input  wire                                      reset_n,
    input  wire ip_frag_pkg::frag_request_t [ip_frag_pkg::RECEIVE_QUEUE_SLOTS-1:0] requests,
    input  wire ip_frag_pkg::byte_t [ip_frag_pkg::RECEIVE_QUEUE_SLOTS-1:0]         data,
    input  wire [ip_frag_pkg::RECEIVE_QUEUE_SLOTS-1:0]                             data_valid,
    output logic [ip_frag_pkg::RECEIVE_QUEUE_SLOTS-1:0]                            data_ready,
    output ip_frag_pkg::push_beat_t                                                push_beat,
    output logic [ip_frag_pkg::FRAGMENT_SLOTS-1:0]                                 push_valid,
    output ip_frag_pkg::packet_id_t                                                push_packet_id,
    input  wire [ip_frag_pkg::FRAGMENT_SLOTS-1:0]                                  slot_empty,
    input  wire ip_frag_pkg::packet_id_t [ip_frag_pkg::FRAGMENT_SLOTS-1:0]         slot_packet_id
);

import ip_frag_pkg::*;

typedef enum logic [2:0] {
    idle,
    check_status,
    find_empty_slot,
    find_matching_slot,
    push_data,
    discard_data
} state_t;

state_t                    state;
state_t                    state_next;
port_index_t               port_sel;
port_index_t               port_sel_next;
port_index_t               next_port;
slot_index_t               slot_sel;
slot_index_t               slot_sel_next;
frag_header_t              header;
byte_t                     hold_data;
logic                      hold_valid;
logic                      pop;
logic                      last_slot;
logic                      timer_enable;
logic                      timer_load;
logic                      timer_expired;
logic [FRAGMENT_SLOTS-1:0] slot_onehot;

cycle_timer i_push_timer (
    .clock      (clock),
    .reset_n    (reset_n),
    .enable     (timer_enable),
    .load_count (timer_load),
    .count      (TIMEOUT_LIMIT),
    .expired    (timer_expired)
);

assign timer_enable   = (state == push_data);
assign push_packet_id = header.packet_id;
assign last_slot      = (slot_sel == slot_index_t'(FRAGMENT_SLOTS - 1));
assign next_port      = (port_sel == port_index_t'(RECEIVE_QUEUE_SLOTS - 1)) ?
                        '0 : port_sel + port_index_t'(1);

// Pops happen for both pushing and draining
assign pop = ((state == push_data) || (state == discard_data)) && data_valid[port_sel];

always_comb begin
    data_ready           = '0;
    data_ready[port_sel] = pop;
    slot_onehot          = '0;
    slot_onehot[slot_sel] = 1'b1;
end

//////////////////////////////////////////////////
// Dispatch FSM
//////////////////////////////////////////////////

always_comb begin
    state_next    = state;
    port_sel_next = port_sel;
    slot_sel_next = slot_sel;
    timer_load    = 1'b0;

    case (state)
        idle: begin
            if (requests[port_sel].valid) begin
                state_next = check_status;
            end
            else begin
                port_sel_next = next_port;
            end
        end
        check_status: begin
            slot_sel_next = '0;
            if (header.offset == '0) begin
                state_next = find_empty_slot;
            end
            else begin
                state_next = find_matching_slot;
            end
        end
        find_empty_slot: begin
            timer_load = 1'b1;
            if (slot_empty[slot_sel]) begin
                state_next = push_data;
            end
            else if (last_slot) begin
                state_next = discard_data;
            end
            else begin
                slot_sel_next = slot_sel + slot_index_t'(1);
            end
        end
        find_matching_slot: begin
            timer_load = 1'b1;
            if (!slot_empty[slot_sel] && (slot_packet_id[slot_sel] == header.packet_id)) begin
                state_next = push_data;
            end
            else if (last_slot) begin
                state_next = discard_data;
            end
            else begin
                slot_sel_next = slot_sel + slot_index_t'(1);
            end
        end
        push_data: begin
            timer_load = pop;
            if (timer_expired) begin
                state_next    = idle;
                port_sel_next = next_port;
            end
        end
        discard_data: begin
            if (!requests[port_sel].valid) begin
                state_next    = idle;
                port_sel_next = next_port;
            end
        end
        default: begin
            state_next = idle;
        end
    endcase
end

// One byte is held back so that last can ride on the final byte
always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        state      <= idle;
        port_sel   <= '0;
        slot_sel   <= '0;
        hold_valid <= 1'b0;
        push_valid <= '0;
        push_beat  <= '0;
    end
    else begin
        state          <= state_next;
        port_sel       <= port_sel_next;
        slot_sel       <= slot_sel_next;
        push_valid     <= '0;
        push_beat.last <= 1'b0;
        if (state == push_data) begin
            if (hold_valid) begin
                push_valid     <= slot_onehot;
                push_beat.data <= hold_data;
                push_beat.last <= !pop && !header.more_fragments;
            end
            hold_valid <= pop;
        end
    end
end

always_ff @(posedge clock) begin
    if ((state == idle) && requests[port_sel].valid) begin
        header <= requests[port_sel].header;
    end
    if (pop) begin
        hold_data <= data[port_sel];
    end
end

// Target slot stays free or keeps this fragment's identification
a_push_target: assert property (@(posedge clock) disable iff (!reset_n)
    (state == push_data) |-> slot_empty[slot_sel] ||
        (slot_packet_id[slot_sel] == header.packet_id))
    else $error("udp_receive_handler: push target slot taken by another datagram");

endmodule

`default_nettype wire

/* rtl/ip_reassembly_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_reassembly_top (
    input  wire                                                                  clock,
    input  wire                                                                  reset_n,
    input  wire ip_frag_pkg::frag_header_t [ip_frag_pkg::RECEIVE_QUEUE_SLOTS-1:0] in_header,
    input  wire ip_frag_pkg::byte_beat_t [ip_frag_pkg::RECEIVE_QUEUE_SLOTS-1:0]   in_beat,
    input  wire [ip_frag_pkg::RECEIVE_QUEUE_SLOTS-1:0]                           in_valid,
    output wire [ip_frag_pkg::RECEIVE_QUEUE_SLOTS-1:0]                           in_ready,
    output wire ip_frag_pkg::byte_beat_t [ip_frag_pkg::FRAGMENT_SLOTS-1:0]        out_beat,
    output wire [ip_frag_pkg::FRAGMENT_SLOTS-1:0]                                out_valid,
    input  wire [ip_frag_pkg::FRAGMENT_SLOTS-1:0]                                out_ready,
    output wire ip_frag_pkg::packet_id_t [ip_frag_pkg::FRAGMENT_SLOTS-1:0]        out_packet_id
);

import ip_frag_pkg::*;

wire frag_request_t [RECEIVE_QUEUE_SLOTS-1:0] requests;
wire byte_t [RECEIVE_QUEUE_SLOTS-1:0]         queue_data;
wire [RECEIVE_QUEUE_SLOTS-1:0]                queue_data_valid;
wire [RECEIVE_QUEUE_SLOTS-1:0]                queue_data_ready;
wire push_beat_t                              push_beat;
wire [FRAGMENT_SLOTS-1:0]                     push_valid;
wire packet_id_t                              push_packet_id;
wire [FRAGMENT_SLOTS-1:0]                     slot_empty;
wire packet_id_t [FRAGMENT_SLOTS-1:0]         slot_packet_id;

//////////////////////////////////////////////////
// Receive side
//////////////////////////////////////////////////

for (genvar i = 0; i < RECEIVE_QUEUE_SLOTS; i++) begin : g_queue
    receive_queue i_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .in_header  (in_header[i]),
        .in_beat    (in_beat[i]),
        .in_valid   (in_valid[i]),
        .in_ready   (in_ready[i]),
        .request    (requests[i]),
        .data       (queue_data[i]),
        .data_valid (queue_data_valid[i]),
        .data_ready (queue_data_ready[i])
    );
end

udp_receive_handler i_handler (
    .clock          (clock),
    .reset_n        (reset_n),
    .requests       (requests),
    .data           (queue_data),
    .data_valid     (queue_data_valid),
    .data_ready     (queue_data_ready),
    .push_beat      (push_beat),
    .push_valid     (push_valid),
    .push_packet_id (push_packet_id),
    .slot_empty     (slot_empty),
    .slot_packet_id (slot_packet_id)
);

//////////////////////////////////////////////////
// Reassembly slots
//////////////////////////////////////////////////

for (genvar j = 0; j < FRAGMENT_SLOTS; j++) begin : g_slot
    fragment_slot i_slot (
        .clock          (clock),
        .reset_n        (reset_n),
        .push_beat      (push_beat),
        .push_valid     (push_valid[j]),
        .push_packet_id (push_packet_id),
        .slot_empty     (slot_empty[j]),
        .slot_packet_id (slot_packet_id[j]),
        .out_beat       (out_beat[j]),
        .out_valid      (out_valid[j]),
        .out_ready      (out_ready[j]),
        .out_packet_id  (out_packet_id[j])
    );
end

endmodule

`default_nettype wire

/* tb/tb_ip_reassembly.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ip_reassembly;

import ip_frag_pkg::*;

localparam int WAIT_LIMIT = 1000;

typedef struct packed {
    port_index_t  port;
    packet_id_t   packet_id;
    frag_offset_t offset;
    logic         more_fragments;
    logic [4:0]   length;
    logic         drop;
    logic         stall;
    logic         wait_output;
} row_t;

logic                                   clock;
logic                                   reset_n;
frag_header_t [RECEIVE_QUEUE_SLOTS-1:0] in_header;
byte_beat_t [RECEIVE_QUEUE_SLOTS-1:0]   in_beat;
logic [RECEIVE_QUEUE_SLOTS-1:0]         in_valid;
logic [RECEIVE_QUEUE_SLOTS-1:0]         in_ready;
byte_beat_t [FRAGMENT_SLOTS-1:0]        out_beat;
logic [FRAGMENT_SLOTS-1:0]              out_valid;
logic [FRAGMENT_SLOTS-1:0]              out_ready;
packet_id_t [FRAGMENT_SLOTS-1:0]        out_packet_id;
logic                                   hold_output;

row_t       rows [$];
byte_t      payload [$];
// Reference model of the bytes still owed by each slot
byte_t      expect_bytes [FRAGMENT_SLOTS][$];
packet_id_t expect_id [FRAGMENT_SLOTS];

ip_reassembly_top i_dut (
    .clock         (clock),
    .reset_n       (reset_n),
    .in_header     (in_header),
    .in_beat       (in_beat),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_packet_id (out_packet_id)
);

initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
end

// Random gaps on out_ready unless the table holds output back
task automatic drive_out_ready();
    forever begin
        @(posedge clock);
        #1;
        for (int s = 0; s < FRAGMENT_SLOTS; s++) begin
            out_ready[s] = !hold_output && ($urandom_range(3) != 0);
        end
    end
endtask

//////////////////////////////////////////////////
// Compare and stop
//////////////////////////////////////////////////

task automatic stop_run();
    $display("Finished with errors");
    $fatal(1);
endtask

task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
        $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
        stop_run();
    end
endtask

task automatic check_packet_id(input string name, input packet_id_t expected,
                               input packet_id_t actual);
    if (actual !== expected) begin
        $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
        stop_run();
    end
endtask

task automatic check_last(input string name, input bit expected, input bit actual);
    if (actual !== expected) begin
        $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
        stop_run();
    end
endtask

function automatic int pending_bytes();
    int total;
    total = 0;
    for (int s = 0; s < FRAGMENT_SLOTS; s++) begin
        total += expect_bytes[s].size();
    end
    return total;
endfunction

task automatic check_output_beat(input int s);
    if (expect_bytes[s].size() == 0) begin
        $display("Slot %0d streams a datagram that no accepted fragment explains", s);
        stop_run();
    end
    check_packet_id($sformatf("out_packet_id[%0d]", s), expect_id[s], out_packet_id[s]);
    if (out_ready[s]) begin
        check_byte($sformatf("out_beat[%0d].data", s), expect_bytes[s][0], out_beat[s].data);
        check_last($sformatf("out_beat[%0d].last", s), expect_bytes[s].size() == 1,
                   out_beat[s].last);
        void'(expect_bytes[s].pop_front());
    end
endtask

// Outputs sampled mid-cycle
initial begin
    forever begin
        @(negedge clock);
        for (int s = 0; s < FRAGMENT_SLOTS; s++) begin
            if (reset_n && out_valid[s]) begin
                check_output_beat(s);
            end
        end
    end
end

//////////////////////////////////////////////////
// Stimulus
//////////////////////////////////////////////////

task automatic add_row(input port_index_t port, input packet_id_t id,
                       input frag_offset_t offset, input logic more_fragments,
                       input int length, input logic drop, input logic stall,
                       input logic wait_output);
    row_t row;
    row = '{port: port, packet_id: id, offset: offset, more_fragments: more_fragments,
            length: 5'(length), drop: drop, stall: stall, wait_output: wait_output};
    rows.push_back(row);
endtask

// Lowest empty slot for a first fragment, matching slot otherwise
function automatic int predict_slot(input row_t row);
    int found;
    found = -1;
    for (int s = FRAGMENT_SLOTS - 1; s >= 0; s--) begin
        if ((row.offset == '0) && (expect_bytes[s].size() == 0)) begin
            found = s;
        end
        if ((row.offset != '0) && (expect_bytes[s].size() != 0) &&
            (expect_id[s] == row.packet_id)) begin
            found = s;
        end
    end
    return found;
endfunction

task automatic send_fragment(input port_index_t port, input frag_header_t header);
    int beat;
    int cycles;
    beat = 0;
    cycles = 0;
    while (beat < payload.size()) begin
        in_valid[port]  = 1'b1;
        in_header[port] = header;
        in_beat[port]   = '{data: payload[beat], last: (beat == payload.size() - 1)};
        @(negedge clock);
        if (in_ready[port]) begin
            beat++;
            cycles = 0;
        end
        else begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timed out waiting for port %0d to accept a byte", port);
                stop_run();
            end
        end
        @(posedge clock);
        #1;
    end
    in_valid[port] = 1'b0;
    in_beat[port]  = '0;
endtask

task automatic wait_queue_drained(input port_index_t port);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!in_ready[port]) begin
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            $display("Timed out waiting for receive queue %0d to take input again", port);
            stop_run();
        end
        @(negedge clock);
    end
    @(posedge clock);
    #1;
endtask

task automatic wait_output_done();
    int cycles;
    cycles = 0;
    while (pending_bytes() != 0) begin
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            $display("Timed out waiting for the reassembled datagrams to stream out");
            stop_run();
        end
        @(negedge clock);
    end
    @(posedge clock);
    #1;
endtask

task automatic apply_row(input row_t row);
    frag_header_t header;
    int           slot;
    header = '{packet_id: row.packet_id, more_fragments: row.more_fragments,
               offset: row.offset};
    hold_output = row.stall;
    payload.delete();
    for (int n = 0; n < int'(row.length); n++) begin
        payload.push_back(byte_t'($urandom));
    end
    if (!row.drop) begin
        slot = predict_slot(row);
        if (slot < 0) begin
            $display("No slot can take fragment 0x%h that should be kept", row.packet_id);
            stop_run();
        end
        expect_id[slot] = row.packet_id;
        foreach (payload[n]) begin
            expect_bytes[slot].push_back(payload[n]);
        end
    end
    send_fragment(row.port, header);
    wait_queue_drained(row.port);
    if (row.wait_output) begin
        hold_output = 1'b0;
        wait_output_done();
    end
endtask

task automatic load_table();
    // Port, id, offset, more fragments, length, drop, stall, wait
    add_row(1'b0, 16'h1001, 13'd0, 1'b0, 12, 1'b0, 1'b0, 1'b1);
    add_row(1'b1, 16'h2002, 13'd0, 1'b1, 16, 1'b0, 1'b0, 1'b0);
    add_row(1'b0, 16'h2002, 13'd2, 1'b0, 9, 1'b0, 1'b0, 1'b1);
    // Orphan non-first fragment
    add_row(1'b1, 16'h3bad, 13'd3, 1'b0, 8, 1'b1, 1'b0, 1'b0);
    add_row(1'b1, 16'h3003, 13'd0, 1'b0, 5, 1'b0, 1'b0, 1'b1);
    // Both slots held so the third datagram has nowhere to go
    add_row(1'b0, 16'h4001, 13'd0, 1'b0, 10, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, 16'h4002, 13'd0, 1'b0, 7, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 16'h4003, 13'd0, 1'b0, 6, 1'b1, 1'b1, 1'b1);
    add_row(1'b0, 16'h5001, 13'd0, 1'b1, 16, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 16'h5001, 13'd2, 1'b1, 16, 1'b0, 1'b0, 1'b0);
    add_row(1'b0, 16'h5001, 13'd4, 1'b0, 11, 1'b0, 1'b0, 1'b1);
    add_row(1'b1, 16'h5002, 13'd0, 1'b0, 13, 1'b0, 1'b0, 1'b1);
    // Two datagrams interleaved over both slots
    add_row(1'b0, 16'h5003, 13'd0, 1'b1, 8, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 16'h5004, 13'd0, 1'b1, 8, 1'b0, 1'b0, 1'b0);
    add_row(1'b0, 16'h5003, 13'd1, 1'b0, 4, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 16'h5004, 13'd1, 1'b0, 6, 1'b0, 1'b0, 1'b1);
endtask

initial begin
    void'($urandom(32'hd1bd_4990));
    reset_n     = 1'b0;
    in_header   = '0;
    in_beat     = '0;
    in_valid    = '0;
    out_ready   = '0;
    hold_output = 1'b0;
    fork
        drive_out_ready();
    join_none
    load_table();
    repeat (5) @(posedge clock);
    #1;
    reset_n = 1'b1;
    @(posedge clock);
    #1;
    foreach (rows[i]) begin
        apply_row(rows[i]);
    end
    $display("Finished with no errors");
    $finish;
end

endmodule

`default_nettype wire

/* build.f */
rtl/ip_frag_pkg.sv
rtl/cycle_timer.sv
rtl/receive_queue.sv
rtl/fragment_slot.sv
rtl/udp_receive_handler.sv
rtl/ip_reassembly_top.sv
tb/tb_ip_reassembly.sv

/* run.sh */
#!/bin/sh
# Compile and run the IPv4 reassembly testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_ip_reassembly \
    -o sim_tb_ip_reassembly
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb_ip_reassembly > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation reported errors"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
